// File: src.f
+incdir+source
source/snake_pkg.sv
source/headStepper.sv
source/bodyStore.sv
source/applePlacer.sv
source/collisionJudge.sv
source/scoreTracker.sv
source/snakeTop.sv
verif/tb_snakeTop.sv

// File: run.sh
#!/bin/sh
# build and run the snake core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_snakeTop -o simv \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qF '>>> PASS' && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: verif/tb_snakeTop.sv
// Snake core testbench
`timescale 1ns/100ps
`include "snake_defines.svh"

module tb_snakeTop;

  // outcome of one step as the model sees it
  typedef enum logic [1:0] {
    NONE,
    MOVE,
    GOOD,
    BAD
  } stepClassT;

  localparam int MOVE_STEPS    = 24;
  localparam int APPLE_COUNT   = 8;
  localparam int ROUTE_LIMIT   = 40;
  localparam int SEARCH_LIMIT  = 300;
  // button press, sync pulse and observe window
  localparam int STEP_CYCLES   = 12;
  localparam int PLANNED_SYNCS = MOVE_STEPS + APPLE_COUNT * ROUTE_LIMIT + 25;
  // 4 ns per cycle, twice the planned run
  localparam int WATCHDOG_NS   = 2 * 4 * (PLANNED_SYNCS * STEP_CYCLES +
                                          (APPLE_COUNT + 4) * SEARCH_LIMIT);
  localparam int WALL          = (1 << `SNAKE_GRID_BITS) - 1;

  logic                 hwclk;
  logic                 rst;
  logic                 sync;
  logic [3:0]           dirPb;
  snake_pkg::cellT      head;
  snake_pkg::lengthT    length;
  snake_pkg::cellT      appleCell;
  logic                 appleValid;
  logic                 goodColl;
  logic                 badColl;
  snake_pkg::scoreT     score;
  snake_pkg::gameStateT gameState;

  // reference model, body[0] is the head
  snake_pkg::cellT      body[$];
  snake_pkg::dirT       modelDir;
  snake_pkg::gameStateT modelState;
  int                   modelScore;
  snake_pkg::cellT      lastNext;
  logic [31:0]          randState;

  snakeTop u_snakeTop (
    .hwclk(hwclk), .rst(rst), .sync(sync), .dirPb(dirPb),
    .head(head), .length(length), .appleCell(appleCell), .appleValid(appleValid),
    .goodColl(goodColl), .badColl(badColl), .score(score), .gameState(gameState)
  );

  always #2 hwclk = ~hwclk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic snake_pkg::dirT reverseOf(input snake_pkg::dirT d);
    case (d)
      snake_pkg::UP:   return snake_pkg::DOWN;
      snake_pkg::DOWN: return snake_pkg::UP;
      snake_pkg::LEFT: return snake_pkg::RIGHT;
      default:         return snake_pkg::LEFT;
    endcase
  endfunction

  // quarter turn clockwise, y grows downward
  function automatic snake_pkg::dirT turnCw(input snake_pkg::dirT d);
    case (d)
      snake_pkg::UP:    return snake_pkg::RIGHT;
      snake_pkg::RIGHT: return snake_pkg::DOWN;
      snake_pkg::DOWN:  return snake_pkg::LEFT;
      default:          return snake_pkg::UP;
    endcase
  endfunction

  function automatic snake_pkg::cellT moveCell(input snake_pkg::cellT c, input snake_pkg::dirT d);
    snake_pkg::cellT n;
    n = c;
    case (d)
      snake_pkg::UP:   n.y = c.y - 4'd1;
      snake_pkg::DOWN: n.y = c.y + 4'd1;
      snake_pkg::LEFT: n.x = c.x - 4'd1;
      default:         n.x = c.x + 4'd1;
    endcase
    return n;
  endfunction

  function automatic bit onWall(input snake_pkg::cellT c);
    return c.x == 0 || c.x == WALL || c.y == 0 || c.y == WALL;
  endfunction

  // tail included, it has not moved yet when the head arrives
  function automatic bit onBody(input snake_pkg::cellT c);
    foreach (body[i]) begin
      if (body[i] == c) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic bit safeStep(input snake_pkg::dirT d, input bit boxed, input bit avoidApple);
    snake_pkg::cellT n;
    n = moveCell(body[0], d);
    if (d == reverseOf(modelDir) || onWall(n) || onBody(n)) begin
      return 1'b0;
    end
    // box of 3 to 12 keeps random walks clear of the wall
    if (boxed && (n.x < 3 || n.x > 12 || n.y < 3 || n.y > 12)) begin
      return 1'b0;
    end
    return !(avoidApple && appleValid && n == appleCell);
  endfunction

  function automatic snake_pkg::dirT pickSafe();
    for (int k = 0; k < 8; k++) begin
      if (safeStep(snake_pkg::dirT'(k % 4), k < 4, 1'b1)) begin
        return snake_pkg::dirT'(k % 4);
      end
    end
    return modelDir;
  endfunction

  // greedy route, longer axis first
  function automatic snake_pkg::dirT chooseToward();
    snake_pkg::dirT order[4];
    snake_pkg::dirT xd;
    snake_pkg::dirT yd;
    int dx;
    int dy;
    dx = int'(appleCell.x) - int'(body[0].x);
    dy = int'(appleCell.y) - int'(body[0].y);
    xd = (dx > 0) ? snake_pkg::RIGHT : snake_pkg::LEFT;
    yd = (dy > 0) ? snake_pkg::DOWN : snake_pkg::UP;
    if (dx * dx >= dy * dy) begin
      order = '{xd, yd, reverseOf(yd), reverseOf(xd)};
    end else begin
      order = '{yd, xd, reverseOf(xd), reverseOf(yd)};
    end
    foreach (order[k]) begin
      if (safeStep(order[k], 1'b0, 1'b0)) begin
        return order[k];
      end
    end
    return modelDir;
  endfunction

  function automatic stepClassT predict(input snake_pkg::cellT n);
    if (modelState != snake_pkg::PLAY) begin
      return NONE;
    end
    if (onWall(n) || onBody(n)) begin
      return BAD;
    end
    return (appleValid && n == appleCell) ? GOOD : MOVE;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      failRun($sformatf("Error %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic pressButton(input snake_pkg::dirT d);
    @(posedge hwclk);
    dirPb <= 4'b1000 >> d;
    @(posedge hwclk);
    dirPb <= 4'b0000;
  endtask

  task automatic waitApple();
    int count;
    count = 0;
    while (!appleValid && count < SEARCH_LIMIT) begin
      @(negedge hwclk);
      count++;
    end
    if (!appleValid) begin
      failRun("apple search did not finish in time");
    end
  endtask

  task automatic checkApple();
    waitApple();
    checkValue("appleOnWall", 32'(onWall(appleCell)), 32'd0);
    checkValue("appleOnBody", 32'(onBody(appleCell)), 32'd0);
  endtask

  // one sync, then compare pulses and state with the model
  task automatic stepSnake(input snake_pkg::dirT want, output stepClassT cls);
    int goodCount;
    int badCount;
    if (modelState == snake_pkg::PLAY) begin
      waitApple();
    end
    if (want != modelDir) begin
      pressButton(want);
      if (want != reverseOf(modelDir)) begin
        modelDir = want;
      end
    end
    @(negedge hwclk);
    lastNext = moveCell(body[0], modelDir);
    cls = predict(lastNext);
    @(posedge hwclk);
    sync <= 1'b1;
    @(posedge hwclk);
    sync <= 1'b0;
    goodCount = 0;
    badCount = 0;
    repeat (8) begin
      @(negedge hwclk);
      goodCount += int'(goodColl);
      badCount += int'(badColl);
    end
    case (cls)
      MOVE: begin
        body.push_front(lastNext);
        void'(body.pop_back());
      end
      GOOD: begin
        body.push_front(lastNext);
        modelScore++;
        if (body.size() == `SNAKE_MAX_LENGTH) begin
          modelState = snake_pkg::WON;
        end
      end
      BAD: modelState = snake_pkg::LOST;
      default: ;
    endcase
    checkValue("goodColl", 32'(goodCount), 32'(cls == GOOD));
    checkValue("badColl", 32'(badCount), 32'(cls == BAD));
    checkValue("head", 32'(head), 32'(body[0]));
    checkValue("length", 32'(length), 32'(body.size()));
    checkValue("score", 32'(score), {24'd0, 4'(modelScore / 10), 4'(modelScore % 10)});
    checkValue("gameState", 32'(gameState), 32'(modelState));
  endtask

  task automatic eatApple();
    stepClassT cls;
    int startScore;
    int steps;
    startScore = modelScore;
    steps = 0;
    while (modelScore == startScore) begin
      if (steps >= ROUTE_LIMIT || modelState != snake_pkg::PLAY) begin
        failRun("snake did not reach the apple");
      end
      waitApple();
      stepSnake(chooseToward(), cls);
      steps++;
    end
    if (modelState == snake_pkg::PLAY) begin
      checkApple();
    end
  endtask

  task automatic applyReset();
    snake_pkg::cellT c;
    @(posedge hwclk);
    rst <= 1'b1;
    sync <= 1'b0;
    dirPb <= 4'b0000;
    repeat (4) @(posedge hwclk);
    rst <= 1'b0;
    body.delete();
    for (int i = 0; i < `SNAKE_START_LENGTH; i++) begin
      c.x = snake_pkg::coordT'(`SNAKE_START_X - i);
      c.y = snake_pkg::coordT'(`SNAKE_START_Y);
      body.push_back(c);
    end
    modelDir = snake_pkg::RIGHT;
    modelState = snake_pkg::PLAY;
    modelScore = 0;
  endtask

  task automatic testReset();
    @(negedge hwclk);
    checkValue("head", 32'(head), 32'(body[0]));
    checkValue("length", 32'(length), 32'(`SNAKE_START_LENGTH));
    checkValue("score", 32'(score), 32'd0);
    checkValue("gameState", 32'(gameState), 32'(snake_pkg::PLAY));
    checkValue("goodColl", 32'(goodColl), 32'd0);
    checkValue("badColl", 32'(badColl), 32'd0);
    // search starts over, no apple yet
    checkValue("appleValid", 32'(appleValid), 32'd0);
    checkApple();
  endtask

  task automatic testMoves();
    snake_pkg::dirT d;
    stepClassT cls;
    for (int i = 0; i < MOVE_STEPS; i++) begin
      waitApple();
      randState = xorshift(randState);
      d = snake_pkg::dirT'(randState[1:0]);
      // reversal press, heading must stay
      if (d == reverseOf(modelDir)) begin
        pressButton(d);
        d = modelDir;
        @(negedge hwclk);
      end
      if (!safeStep(d, 1'b1, 1'b1)) begin
        d = pickSafe();
      end
      stepSnake(d, cls);
      checkValue("length", 32'(length), 32'(`SNAKE_START_LENGTH));
    end
  endtask

  task automatic testEat();
    int startLength;
    startLength = body.size();
    eatApple();
    checkValue("length", 32'(length), 32'(startLength + 1));
  endtask

  task automatic testResetMidGame();
    checkValue("grownLength", 32'(length > `SNAKE_START_LENGTH), 32'd1);
    applyReset();
    testReset();
  endtask

  task automatic testWin();
    stepClassT cls;
    while (body.size() < `SNAKE_MAX_LENGTH) begin
      eatApple();
    end
    checkValue("gameState", 32'(gameState), 32'(snake_pkg::WON));
    // frozen game ignores sync
    stepSnake(modelDir, cls);
  endtask

  task automatic testWallCrash();
    stepClassT cls;
    applyReset();
    testReset();
    cls = NONE;
    for (int k = 0; k < 16 && cls != BAD; k++) begin
      stepSnake(modelDir, cls);
    end
    checkValue("gameState", 32'(gameState), 32'(snake_pkg::LOST));
    // head stops on the last free cell of the start row
    checkValue("head", 32'(head),
               {24'd0, snake_pkg::coordT'(WALL - 1), snake_pkg::coordT'(`SNAKE_START_Y)});
  endtask

  task automatic testSelfCrash();
    stepClassT cls;
    bit useCw;
    applyReset();
    testReset();
    eatApple();
    eatApple();
    // turn away from a wall, the third turn meets the neck
    useCw = !onWall(moveCell(body[0], turnCw(modelDir)));
    cls = NONE;
    for (int k = 0; k < 8 && cls != BAD; k++) begin
      waitApple();
      stepSnake(useCw ? turnCw(modelDir) : reverseOf(turnCw(modelDir)), cls);
    end
    checkValue("crashOnWall", 32'(onWall(lastNext)), 32'd0);
    checkValue("gameState", 32'(gameState), 32'(snake_pkg::LOST));
  endtask

  initial begin
    #(WATCHDOG_NS);
    failRun("simulation timed out");
  end

  initial begin
    hwclk = 1'b0;
    rst = 1'b1;
    sync = 1'b0;
    dirPb = 4'b0000;
    randState = 32'd86;
    applyReset();
    testReset();
    testMoves();
    testEat();
    testResetMidGame();
    testWin();
    testWallCrash();
    testSelfCrash();
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: source/snakeTop.sv
// Snake game core top level
`timescale 1ns/100ps
`default_nettype none

module snakeTop (
  input  logic                 hwclk,
  input  logic                 rst,
  input  logic                 sync,
  input  logic [3:0]           dirPb,
  output snake_pkg::cellT      head,
  output snake_pkg::lengthT    length,
  output snake_pkg::cellT      appleCell,
  output logic                 appleValid,
  output logic                 goodColl,
  output logic                 badColl,
  output snake_pkg::scoreT     score,
  output snake_pkg::gameStateT gameState
);

  logic            stepReq;
  logic            moveOk;
  logic            push;
  logic            bodyHit;
  logic            appleHit;
  snake_pkg::cellT nextHead;
  snake_pkg::cellT candidate;

  // producer, one request per frame
  headStepper u_headStepper (
    .hwclk(hwclk), .rst(rst), .sync(sync), .dirPb(dirPb),
    .gameState(gameState), .head(head),
    .stepReq(stepReq), .nextHead(nextHead)
  );

  // body advances on a move or an eat, never on a crash
  assign push = goodColl | moveOk;

  // head query checks the request, apple query checks the candidate
  bodyStore u_bodyStore (
    .hwclk(hwclk), .rst(rst), .push(push), .grow(goodColl),
    .newHead(nextHead), .headQuery(nextHead), .appleQuery(candidate),
    .head(head), .length(length), .bodyHit(bodyHit), .appleHit(appleHit)
  );

  applePlacer u_applePlacer (
    .hwclk(hwclk), .rst(rst), .goodColl(goodColl), .appleHit(appleHit),
    .candidate(candidate), .appleCell(appleCell), .appleValid(appleValid)
  );

  collisionJudge u_collisionJudge (
    .hwclk(hwclk), .rst(rst), .stepReq(stepReq), .nextHead(nextHead),
    .bodyHit(bodyHit), .appleCell(appleCell), .appleValid(appleValid),
    .goodColl(goodColl), .badColl(badColl), .moveOk(moveOk)
  );

  scoreTracker u_scoreTracker (
    .hwclk(hwclk), .rst(rst), .goodColl(goodColl), .badColl(badColl),
    .length(length), .score(score), .gameState(gameState)
  );

endmodule

// File: source/scoreTracker.sv
// Score and game state tracker
`timescale 1ns/100ps
`default_nettype none
`include "snake_defines.svh"

module scoreTracker (
  input  logic                 hwclk,
  input  logic                 rst,
  input  logic                 goodColl,
  input  logic                 badColl,
  input  snake_pkg::lengthT    length,
  output snake_pkg::scoreT     score,
  output snake_pkg::gameStateT gameState
);

  // length is updated one cycle after the eat pulse
  logic winCheck;

  always_ff @(posedge hwclk) begin
    if (rst) begin
      winCheck <= 1'b0;
    end else begin
      winCheck <= goodColl;
    end
  end

  // two-digit BCD count of apples eaten
  always_ff @(posedge hwclk) begin
    if (rst) begin
      score <= '0;
    end else if (goodColl) begin
      if (score.ones == 4'd9) begin
        score.ones <= '0;
        // tens rolls over at 99
        if (score.tens == 4'd9) begin
          score.tens <= '0;
        end else begin
          score.tens <= score.tens + 1'b1;
        end
      end else begin
        score.ones <= score.ones + 1'b1;
      end
    end
  end

  // PLAY until the first crash or a full body
  always_ff @(posedge hwclk) begin
    if (rst) begin
      gameState <= snake_pkg::PLAY;
    end else if (gameState == snake_pkg::PLAY) begin
      if (badColl) begin
        gameState <= snake_pkg::LOST;
      end else if (winCheck &&
                   length == snake_pkg::lengthT'(`SNAKE_MAX_LENGTH)) begin
        gameState <= snake_pkg::WON;
      end
    end
  end

endmodule

// File: source/collisionJudge.sv
// Collision judge
`timescale 1ns/100ps
`default_nettype none
`include "snake_defines.svh"

module collisionJudge (
  input  logic            hwclk,
  input  logic            rst,
  input  logic            stepReq,
  input  snake_pkg::cellT nextHead,
  input  logic            bodyHit,
  input  snake_pkg::cellT appleCell,
  input  logic            appleValid,
  output logic            goodColl,
  output logic            badColl,
  output logic            moveOk
);

  logic onWall;
  logic isBad;
  logic isGood;

  // outer ring of the grid
  assign onWall = nextHead.x == '0 ||
                  nextHead.x == snake_pkg::coordT'(`SNAKE_WALL_MAX) ||
                  nextHead.y == '0 ||
                  nextHead.y == snake_pkg::coordT'(`SNAKE_WALL_MAX);

  // crash wins over eat, eat over move
  assign isBad  = onWall || bodyHit;
  assign isGood = !isBad && appleValid && (nextHead == appleCell);

  // exactly one pulse per request
  always_ff @(posedge hwclk) begin
    if (rst) begin
      badColl  <= 1'b0;
      goodColl <= 1'b0;
      moveOk   <= 1'b0;
    end else begin
      badColl  <= stepReq && isBad;
      goodColl <= stepReq && isGood;
      moveOk   <= stepReq && !isBad && !isGood;
    end
  end

endmodule

// File: source/applePlacer.sv
// Apple placer
`timescale 1ns/100ps
`default_nettype none
`include "snake_defines.svh"

module applePlacer (
  input  logic            hwclk,
  input  logic            rst,
  input  logic            goodColl,
  input  logic            appleHit,
  output snake_pkg::cellT candidate,
  output snake_pkg::cellT appleCell,
  output logic            appleValid
);

  typedef enum logic {
    SEARCH,
    HOLD
  } placeStateT;

  placeStateT state;
  logic [7:0] lfsr;
  logic       interior;

  // x^8 + x^6 + x^5 + x^4 + 1, all 255 nonzero states
  always_ff @(posedge hwclk) begin
    if (rst) begin
      lfsr <= `SNAKE_RAND_SEED;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  // upper nibble is x, lower nibble is y
  assign candidate = '{x: lfsr[7:4], y: lfsr[3:0]};

  // walls on both ends of each axis
  assign interior = candidate.x != '0 &&
                    candidate.x != snake_pkg::coordT'(`SNAKE_WALL_MAX) &&
                    candidate.y != '0 &&
                    candidate.y != snake_pkg::coordT'(`SNAKE_WALL_MAX);

  // search restarts once the eaten apple is gone
  // body is stale in the goodColl cycle, so no accept there
  always_ff @(posedge hwclk) begin
    if (rst) begin
      state <= SEARCH;
    end else if (goodColl) begin
      state <= SEARCH;
    end else if (state == SEARCH && interior && !appleHit) begin
      state <= HOLD;
    end
  end

  // accepted cell, meaningful only in HOLD
  always_ff @(posedge hwclk) begin
    if (state == SEARCH && interior && !appleHit) begin
      appleCell <= candidate;
    end
  end

  assign appleValid = (state == HOLD);

endmodule

// File: source/bodyStore.sv
// Snake body store
`timescale 1ns/100ps
`default_nettype none
`include "snake_defines.svh"

module bodyStore (
  input  logic              hwclk,
  input  logic              rst,
  input  logic              push,
  input  logic              grow,
  input  snake_pkg::cellT   newHead,
  input  snake_pkg::cellT   headQuery,
  input  snake_pkg::cellT   appleQuery,
  output snake_pkg::cellT   head,
  output snake_pkg::lengthT length,
  output logic              bodyHit,
  output logic              appleHit
);

  // cells[0] is the head, cells[length-1] the tail
  snake_pkg::cellT cells [`SNAKE_MAX_LENGTH];

  // shift chain, reset loads the start snake
  always_ff @(posedge hwclk) begin
    if (rst) begin
      for (int i = 0; i < `SNAKE_START_LENGTH; i++) begin
        cells[i].x <= snake_pkg::coordT'(`SNAKE_START_X - i);
        cells[i].y <= snake_pkg::coordT'(`SNAKE_START_Y);
      end
    end else if (push) begin
      cells[0] <= newHead;
      // old tail falls past length on a plain move
      for (int i = 1; i < `SNAKE_MAX_LENGTH; i++) begin
        cells[i] <= cells[i-1];
      end
    end
  end

  // tail kept on an eat, so one more cell is valid
  always_ff @(posedge hwclk) begin
    if (rst) begin
      length <= snake_pkg::lengthT'(`SNAKE_START_LENGTH);
    end else if (push && grow &&
                 length != snake_pkg::lengthT'(`SNAKE_MAX_LENGTH)) begin
      length <= length + 1'b1;
    end
  end

  assign head = cells[0];

  // two compare banks over the valid cells
  // tail counts as occupied for the head query
  always_comb begin
    bodyHit  = 1'b0;
    appleHit = 1'b0;
    for (int i = 0; i < `SNAKE_MAX_LENGTH; i++) begin
      if (i < int'(length)) begin
        if (cells[i] == headQuery) begin
          bodyHit = 1'b1;
        end
        if (cells[i] == appleQuery) begin
          appleHit = 1'b1;
        end
      end
    end
  end

endmodule

// File: source/headStepper.sv
// Snake head stepper
`timescale 1ns/100ps
`default_nettype none

module headStepper (
  input  logic                  hwclk,
  input  logic                  rst,
  input  logic                  sync,
  // up, down, left, right
  input  logic [3:0]            dirPb,
  input  snake_pkg::gameStateT  gameState,
  input  snake_pkg::cellT       head,
  output logic                  stepReq,
  output snake_pkg::cellT       nextHead
);

  snake_pkg::dirT  dir;
  snake_pkg::dirT  pressDir;
  logic            pressValid;
  logic            isReverse;
  snake_pkg::cellT movedHead;

  // button decode, up has top priority
  always_comb begin
    pressValid = 1'b1;
    pressDir   = dir;
    if (dirPb[3]) begin
      pressDir = snake_pkg::UP;
    end else if (dirPb[2]) begin
      pressDir = snake_pkg::DOWN;
    end else if (dirPb[1]) begin
      pressDir = snake_pkg::LEFT;
    end else if (dirPb[0]) begin
      pressDir = snake_pkg::RIGHT;
    end else begin
      pressValid = 1'b0;
    end
  end

  // a press opposite to the heading would fold the snake onto its neck
  assign isReverse = (pressDir == snake_pkg::UP    && dir == snake_pkg::DOWN) ||
                     (pressDir == snake_pkg::DOWN  && dir == snake_pkg::UP)   ||
                     (pressDir == snake_pkg::LEFT  && dir == snake_pkg::RIGHT) ||
                     (pressDir == snake_pkg::RIGHT && dir == snake_pkg::LEFT);

  // start snake heads right
  always_ff @(posedge hwclk) begin
    if (rst) begin
      dir <= snake_pkg::RIGHT;
    end else if (pressValid && !isReverse) begin
      dir <= pressDir;
    end
  end

  // neighbour cell in the current heading
  // head is always interior, so no wrap
  always_comb begin
    movedHead = head;
    case (dir)
      snake_pkg::UP:    movedHead.y = head.y - 1'b1;
      snake_pkg::DOWN:  movedHead.y = head.y + 1'b1;
      snake_pkg::LEFT:  movedHead.x = head.x - 1'b1;
      default:          movedHead.x = head.x + 1'b1;
    endcase
  end

  // one request per frame, only while playing
  always_ff @(posedge hwclk) begin
    if (rst) begin
      stepReq <= 1'b0;
    end else begin
      stepReq <= sync && (gameState == snake_pkg::PLAY);
    end
  end

  // request cell, qualified by stepReq
  always_ff @(posedge hwclk) begin
    if (sync) begin
      nextHead <= movedHead;
    end
  end

endmodule

// File: source/snake_pkg.sv
// Snake game core types
`include "snake_defines.svh"

package snake_pkg;

  // one grid coordinate
  typedef logic [`SNAKE_GRID_BITS-1:0] coordT;

  // one grid cell, unit of the body store
  typedef struct packed {
    coordT x;
    coordT y;
  } cellT;

  // snake length in cells
  typedef logic [4:0] lengthT;

  // single BCD digit
  typedef logic [3:0] bcdT;

  // heading, UP moves toward y = 0
  typedef enum logic [1:0] {
    UP,
    DOWN,
    LEFT,
    RIGHT
  } dirT;

  // game outcome, LOST and WON are sticky
  typedef enum logic [1:0] {
    PLAY,
    LOST,
    WON
  } gameStateT;

  // two-digit BCD score
  typedef struct packed {
    bcdT tens;
    bcdT ones;
  } scoreT;

endpackage

// File: source/snake_defines.svh
// Snake game core parameters
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// bits per grid coordinate, 16 by 16 playfield
`define SNAKE_GRID_BITS 4
// highest coordinate, the far wall ring
`define SNAKE_WALL_MAX ((1 << `SNAKE_GRID_BITS) - 1)

// body capacity, also the winning length
`define SNAKE_MAX_LENGTH 8

// head cell after reset, body trails to the left
`define SNAKE_START_X 8
`define SNAKE_START_Y 8
`define SNAKE_START_LENGTH 3

// apple LFSR reset value, must be nonzero
`define SNAKE_RAND_SEED 8'hA5

`endif
